/* verilog/kr580_defines.svh */
`ifndef KR580_DEFINES_SVH
`define KR580_DEFINES_SVH

// Bus widths
`define KR580_DATA_W        8
`define KR580_ADDR_W        16

// Bit positions inside F
`define KR580_FLAG_C        0
`define KR580_FLAG_P        2
`define KR580_FLAG_A        4
`define KR580_FLAG_Z        6
`define KR580_FLAG_S        7

// Register codes as they appear in opcode fields
`define KR580_REG_B         3'd0
`define KR580_REG_C         3'd1
`define KR580_REG_D         3'd2
`define KR580_REG_E         3'd3
`define KR580_REG_H         3'd4
`define KR580_REG_L         3'd5
`define KR580_REG_M         3'd6        // Memory operand at HL
`define KR580_REG_A         3'd7

// First fetch address
`define KR580_RESET_PC      16'h0000

// Fixed opcode bytes
`define KR580_OP_HALT       8'h76       // Slot of LD (HL),(HL)
`define KR580_OP_OUT        8'hD3       // OUT (n),A
`define KR580_OP_IN         8'hDB       // IN A,(n)
`define KR580_OP_JP         8'hC3       // Unconditional JP nn

`endif

/* verilog/kr580_pkg.sv */
`default_nettype none

package kr580_pkg;

    // Accumulator operations, same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7
    } alu_op_e;

    // Register and ALU decode view
    typedef struct packed {
        logic [1:0] grp;        // Instruction group
        logic [2:0] dst;        // Destination or ALU operation
        logic [2:0] src;        // Source register
    } opcode_fields_t;

    // Conditional jump view
    typedef struct packed {
        logic [1:0] grp;
        logic [1:0] sel;        // Z, C, P, S
        logic       sense;      // Required flag value
        logic [2:0] low;
    } opcode_cond_t;

    // One opcode byte, decoded two ways
    typedef union packed {
        opcode_fields_t fields;
        opcode_cond_t   cond;
    } opcode_u;

endpackage

`default_nettype wire

/* verilog/kr580_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kr580_defines.svh"

module kr580_alu (
    input  wire kr580_pkg::alu_op_e      alu_op_i,
    input  wire  [`KR580_DATA_W-1:0]     a_i,
    input  wire  [`KR580_DATA_W-1:0]     b_i,
    input  wire                          carry_i,
    output logic [`KR580_DATA_W-1:0]     result_o,
    output logic [`KR580_DATA_W-1:0]     flags_o
);

    import kr580_pkg::*;

    logic       cin;
    logic [8:0] sum9;
    logic [8:0] dif9;
    logic [4:0] sum5;
    logic [4:0] dif5;
    logic       cy;
    logic       hc;

    // Carry only enters ADC and SBC
    assign cin    = ((alu_op_i == ALU_ADC) || (alu_op_i == ALU_SBC)) ? carry_i : 1'b0;

    assign sum9 = {1'b0, a_i} + {1'b0, b_i} + {8'h00, cin};
    assign dif9 = {1'b0, a_i} - {1'b0, b_i} - {8'h00, cin};     // Bit 8 is the borrow
    assign sum5 = {1'b0, a_i[3:0]} + {1'b0, b_i[3:0]} + {4'h0, cin};
    assign dif5 = {1'b0, a_i[3:0]} - {1'b0, b_i[3:0]} - {4'h0, cin};

    always_comb begin
        result_o = sum9[7:0];
        cy       = 1'b0;        // Logic ops leave C and A clear
        hc       = 1'b0;
        case (alu_op_i)
            ALU_ADD,
            ALU_ADC: begin
                result_o = sum9[7:0];
                cy       = sum9[8];
                hc       = sum5[4];
            end
            ALU_SUB,
            ALU_SBC,
            ALU_CP: begin
                result_o = dif9[7:0];
                cy       = dif9[8];
                hc       = dif5[4];     // Low nibble borrow
            end
            ALU_AND: result_o = a_i & b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_OR:  result_o = a_i | b_i;
            default: result_o = sum9[7:0];
        endcase
    end

    // Flag byte in 8080 layout
    always_comb begin
        flags_o                  = 8'h02;       // Bit 1 always set
        flags_o[`KR580_FLAG_S]   = result_o[7];
        flags_o[`KR580_FLAG_Z]   = (result_o == 8'h00);
        flags_o[`KR580_FLAG_P]   = ~^result_o;  // Even parity
        flags_o[`KR580_FLAG_A]   = hc;
        flags_o[`KR580_FLAG_C]   = cy;
    end

endmodule

`default_nettype wire

/* verilog/kr580_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kr580_defines.svh"

module kr580_regfile (
    input  wire                          pin_clk,
    input  wire                          rst_n_i,
    input  wire  [2:0]                   rd_sel_i,
    output logic [`KR580_DATA_W-1:0]     rd_data_o,
    input  wire                          wr_en_i,
    input  wire  [2:0]                   wr_sel_i,
    input  wire  [`KR580_DATA_W-1:0]     wr_data_i,
    input  wire                          flag_wr_i,
    input  wire  [`KR580_DATA_W-1:0]     flag_data_i,
    output logic [`KR580_DATA_W-1:0]     acc_o,
    output logic [`KR580_DATA_W-1:0]     flags_o,
    output logic [`KR580_ADDR_W-1:0]     hl_o
);

    logic [`KR580_DATA_W-1:0] b_q;
    logic [`KR580_DATA_W-1:0] c_q;
    logic [`KR580_DATA_W-1:0] d_q;
    logic [`KR580_DATA_W-1:0] e_q;
    logic [`KR580_DATA_W-1:0] h_q;
    logic [`KR580_DATA_W-1:0] l_q;
    logic [`KR580_DATA_W-1:0] a_q;
    logic [`KR580_DATA_W-1:0] f_q;

    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            b_q <= '0;
            c_q <= '0;
            d_q <= '0;
            e_q <= '0;
            h_q <= '0;
            l_q <= '0;
            a_q <= '0;
            f_q <= '0;
        end else begin
            if (wr_en_i) begin
                case (wr_sel_i)
                    `KR580_REG_B: b_q <= wr_data_i;
                    `KR580_REG_C: c_q <= wr_data_i;
                    `KR580_REG_D: d_q <= wr_data_i;
                    `KR580_REG_E: e_q <= wr_data_i;
                    `KR580_REG_H: h_q <= wr_data_i;
                    `KR580_REG_L: l_q <= wr_data_i;
                    `KR580_REG_A: a_q <= wr_data_i;
                    default:      a_q <= a_q;   // M has no storage here
                endcase
            end
            if (flag_wr_i)
                f_q <= flag_data_i;
        end
    end

    always_comb begin
        case (rd_sel_i)
            `KR580_REG_B: rd_data_o = b_q;
            `KR580_REG_C: rd_data_o = c_q;
            `KR580_REG_D: rd_data_o = d_q;
            `KR580_REG_E: rd_data_o = e_q;
            `KR580_REG_H: rd_data_o = h_q;
            `KR580_REG_L: rd_data_o = l_q;
            default:      rd_data_o = a_q;
        endcase
    end

    assign acc_o   = a_q;
    assign flags_o = (f_q & 8'hD5) | 8'h02;     // Fixed bits 5, 3 and 1
    assign hl_o    = {h_q, l_q};

    // The control maps memory operands away from the read port
    a_rd_not_m: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        rd_sel_i != `KR580_REG_M)
        else $error("register read selects M");

endmodule

`default_nettype wire

/* verilog/kr580_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kr580_defines.svh"

module kr580_control (
    input  wire                          pin_clk,
    input  wire                          rst_n_i,
    input  wire  [`KR580_DATA_W-1:0]     mem_data_i,
    output logic [`KR580_ADDR_W-1:0]     mem_addr_o,
    output logic [`KR580_DATA_W-1:0]     mem_data_o,
    output logic                         mem_wr_o,
    input  wire  [`KR580_DATA_W-1:0]     port_data_i,
    output logic [`KR580_DATA_W-1:0]     port_addr_o,
    output logic [`KR580_DATA_W-1:0]     port_data_o,
    output logic                         port_wr_o,
    output logic                         halt_o,
    output kr580_pkg::alu_op_e           alu_op_o,
    output logic [`KR580_DATA_W-1:0]     alu_a_o,
    output logic [`KR580_DATA_W-1:0]     alu_b_o,
    output logic                         alu_carry_o,
    input  wire  [`KR580_DATA_W-1:0]     alu_result_i,
    input  wire  [`KR580_DATA_W-1:0]     alu_flags_i,
    output logic [2:0]                   rd_sel_o,
    input  wire  [`KR580_DATA_W-1:0]     rd_data_i,
    input  wire  [`KR580_DATA_W-1:0]     acc_i,
    input  wire  [`KR580_DATA_W-1:0]     flags_i,
    input  wire  [`KR580_ADDR_W-1:0]     hl_i,
    output logic                         wr_en_o,
    output logic [2:0]                   wr_sel_o,
    output logic [`KR580_DATA_W-1:0]     wr_data_o,
    output logic                         flag_wr_o,
    output logic [`KR580_DATA_W-1:0]     flag_data_o
);

    import kr580_pkg::*;

    logic [`KR580_ADDR_W-1:0] pc_q;
    logic [1:0]               t_q;          // T-state
    logic                     halt_q;
    opcode_u                  op_q;         // Opcode latched in T0
    opcode_u                  op;
    logic [`KR580_DATA_W-1:0] jp_lo_q;      // Low byte of jump target

    logic                     t1;
    logic                     src_m;
    logic                     dst_m;
    logic                     is_halt;
    logic                     is_ld;
    logic                     is_ldi;
    logic                     is_alu;
    logic                     is_alui;
    logic                     is_jp;
    logic                     is_out;
    logic                     is_in;
    logic                     is_cp;
    logic                     multi;
    logic                     imm_fetch;
    logic                     use_hl;
    logic                     flag_sel;
    logic                     jp_taken;
    logic [`KR580_DATA_W-1:0] operand;

    // In T0 the opcode is still on the bus
    assign op = (t_q == 2'd0) ? mem_data_i : op_q;
    assign t1 = (t_q == 2'd1);

    assign src_m   = (op.fields.src == `KR580_REG_M);
    assign dst_m   = (op.fields.dst == `KR580_REG_M);
    assign is_halt = (op == `KR580_OP_HALT);
    assign is_ld   = (op.fields.grp == 2'b01) && !is_halt;
    assign is_ldi  = (op.fields.grp == 2'b00) && src_m && !dst_m;     // LD r,i8
    assign is_alu  = (op.fields.grp == 2'b10);
    assign is_alui = (op.fields.grp == 2'b11) && src_m;               // ALU A,i8
    assign is_jp   = (op == `KR580_OP_JP) ||
                     ((op.cond.grp == 2'b11) && (op.cond.low == 3'b010));
    assign is_out  = (op == `KR580_OP_OUT);
    assign is_in   = (op == `KR580_OP_IN);

    assign multi     = is_ld || is_ldi || is_alu || is_alui || is_jp || is_out || is_in;
    assign imm_fetch = is_ldi || is_alui || is_jp || is_out || is_in;

    // Condition flag for JP cc
    always_comb begin
        case (op.cond.sel)
            2'd0:    flag_sel = flags_i[`KR580_FLAG_Z];
            2'd1:    flag_sel = flags_i[`KR580_FLAG_C];
            2'd2:    flag_sel = flags_i[`KR580_FLAG_P];
            default: flag_sel = flags_i[`KR580_FLAG_S];
        endcase
    end

    assign jp_taken = (op == `KR580_OP_JP) || (flag_sel == op.cond.sense);

    // Immediates also carry src code M, so they share the bus path
    assign operand = src_m ? mem_data_i : rd_data_i;
    assign use_hl  = t1 && ((is_ld && (src_m || dst_m)) || (is_alu && src_m));

    assign mem_addr_o = use_hl ? hl_i : pc_q;
    assign mem_data_o = rd_data_i;                  // Source of LD (HL),r
    assign mem_wr_o   = t1 && is_ld && dst_m;

    assign port_addr_o = (t1 && (is_out || is_in)) ? mem_data_i : '0;
    assign port_data_o = acc_i;
    assign port_wr_o   = t1 && is_out;

    assign alu_op_o    = alu_op_e'(op.fields.dst);
    assign alu_a_o     = acc_i;
    assign alu_b_o     = operand;
    assign alu_carry_o = flags_i[`KR580_FLAG_C];
    assign is_cp       = (alu_op_o == ALU_CP);

    assign rd_sel_o  = src_m ? `KR580_REG_A : op.fields.src;    // Keep M off the read port
    assign wr_en_o   = t1 && ((is_ld && !dst_m) || is_ldi || is_in ||
                              ((is_alu || is_alui) && !is_cp));
    assign wr_sel_o  = (is_ld || is_ldi) ? op.fields.dst : `KR580_REG_A;
    assign wr_data_o = is_in ? port_data_i :
                       (is_ld || is_ldi) ? operand : alu_result_i;

    assign flag_wr_o   = t1 && (is_alu || is_alui);
    assign flag_data_o = alu_flags_i;

    assign halt_o = halt_q;

    // Sequencer
    always_ff @(posedge pin_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q   <= `KR580_RESET_PC;
            t_q    <= 2'd0;
            halt_q <= 1'b0;
        end else if (!halt_q) begin
            case (t_q)
                2'd0: begin
                    if (is_halt) begin
                        halt_q <= 1'b1;     // PC stays on the HALT byte
                    end else begin
                        pc_q <= pc_q + 1'b1;
                        if (multi)
                            t_q <= 2'd1;
                    end
                end
                2'd1: begin
                    if (imm_fetch)
                        pc_q <= pc_q + 1'b1;
                    t_q <= is_jp ? 2'd2 : 2'd0;
                end
                2'd2: begin
                    pc_q <= jp_taken ? {mem_data_i, jp_lo_q} : pc_q + 1'b1;
                    t_q  <= 2'd0;
                end
                default: t_q <= 2'd0;
            endcase
        end
    end

    // Opcode and jump byte latches
    always_ff @(posedge pin_clk) begin
        if (t_q == 2'd0)
            op_q <= op;
        if (t1)
            jp_lo_q <= mem_data_i;
    end

    a_bus_excl: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        !(mem_wr_o && port_wr_o))
        else $error("memory and port write in the same cycle");

    a_wr_not_m: assert property (@(posedge pin_clk) disable iff (!rst_n_i)
        wr_en_o |-> (wr_sel_o != `KR580_REG_M))
        else $error("register write selects M");

endmodule

`default_nettype wire

/* verilog/kr580_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kr580_defines.svh"

module kr580_core (
    input  wire                          pin_clk,
    input  wire                          rst_n_i,
    input  wire  [`KR580_DATA_W-1:0]     mem_data_i,
    output logic [`KR580_ADDR_W-1:0]     mem_addr_o,
    output logic [`KR580_DATA_W-1:0]     mem_data_o,
    output logic                         mem_wr_o,
    input  wire  [`KR580_DATA_W-1:0]     port_data_i,
    output logic [`KR580_DATA_W-1:0]     port_addr_o,
    output logic [`KR580_DATA_W-1:0]     port_data_o,
    output logic                         port_wr_o,
    output logic                         halt_o
);

    import kr580_pkg::*;

    alu_op_e                  alu_op;
    logic [`KR580_DATA_W-1:0] alu_a;
    logic [`KR580_DATA_W-1:0] alu_b;
    logic                     alu_carry;
    logic [`KR580_DATA_W-1:0] alu_result;
    logic [`KR580_DATA_W-1:0] alu_flags;
    logic [2:0]               rd_sel;
    logic [`KR580_DATA_W-1:0] rd_data;
    logic [`KR580_DATA_W-1:0] acc;
    logic [`KR580_DATA_W-1:0] flags;
    logic [`KR580_ADDR_W-1:0] hl;
    logic                     wr_en;
    logic [2:0]               wr_sel;
    logic [`KR580_DATA_W-1:0] wr_data;
    logic                     flag_wr;
    logic [`KR580_DATA_W-1:0] flag_data;

    kr580_control u_control (
        .pin_clk(pin_clk),         .rst_n_i(rst_n_i),
        .mem_data_i(mem_data_i),   .mem_addr_o(mem_addr_o),
        .mem_data_o(mem_data_o),   .mem_wr_o(mem_wr_o),
        .port_data_i(port_data_i), .port_addr_o(port_addr_o),
        .port_data_o(port_data_o), .port_wr_o(port_wr_o),
        .halt_o(halt_o),
        .alu_op_o(alu_op),         .alu_a_o(alu_a),
        .alu_b_o(alu_b),           .alu_carry_o(alu_carry),
        .alu_result_i(alu_result), .alu_flags_i(alu_flags),
        .rd_sel_o(rd_sel),         .rd_data_i(rd_data),
        .acc_i(acc),               .flags_i(flags),
        .hl_i(hl),
        .wr_en_o(wr_en),           .wr_sel_o(wr_sel),
        .wr_data_o(wr_data),       .flag_wr_o(flag_wr),
        .flag_data_o(flag_data)
    );

    kr580_alu u_alu (
        .alu_op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .carry_i(alu_carry),
        .result_o(alu_result), .flags_o(alu_flags)
    );

    kr580_regfile u_regfile (
        .pin_clk(pin_clk),   .rst_n_i(rst_n_i),
        .rd_sel_i(rd_sel),   .rd_data_o(rd_data),
        .wr_en_i(wr_en),     .wr_sel_i(wr_sel),   .wr_data_i(wr_data),
        .flag_wr_i(flag_wr), .flag_data_i(flag_data),
        .acc_o(acc),         .flags_o(flags),     .hl_o(hl)
    );

endmodule

`default_nettype wire

/* verification/kr580_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "kr580_defines.svh"

module kr580_tb;

    localparam int NUM_ENT = 26;
    localparam int LIMIT   = NUM_ENT * 16 * 3 + 20;     // Cycle budget for the whole run

    logic        pin_clk;
    logic        rst_n_i;
    logic [7:0]  mem_data_i;
    logic [15:0] mem_addr_o;
    logic [7:0]  mem_data_o;
    logic        mem_wr_o;
    logic [7:0]  port_data_i;
    logic [7:0]  port_addr_o;
    logic [7:0]  port_data_o;
    logic        port_wr_o;
    logic        halt_o;

    logic [7:0]  mem [256];
    logic [15:0] outs [$];          // {port, data} per OUT
    int          wr_cnt;
    logic [15:0] wr_addr;
    logic [7:0]  wr_data;
    logic [7:0]  in_addr;

    // Program table
    string       t_name [NUM_ENT];
    logic [7:0]  t_prog [NUM_ENT][16];
    int          t_len  [NUM_ENT];
    int          t_hpos [NUM_ENT];  // Address of the HALT reached
    logic [7:0]  t_in   [NUM_ENT];
    logic [7:0]  t_inp  [NUM_ENT];  // Expected IN port, 0 if unused
    int          t_nexp [NUM_ENT];
    logic [15:0] t_exp  [NUM_ENT][4];
    int          t_wa   [NUM_ENT];  // Expected write address, -1 if none
    logic [7:0]  t_wd   [NUM_ENT];

    int          ne;
    int          err_cnt;
    int          cycles;
    logic [31:0] seed;

    kr580_core uut (
        .pin_clk(pin_clk),         .rst_n_i(rst_n_i),
        .mem_data_i(mem_data_i),   .mem_addr_o(mem_addr_o),
        .mem_data_o(mem_data_o),   .mem_wr_o(mem_wr_o),
        .port_data_i(port_data_i), .port_addr_o(port_addr_o),
        .port_data_o(port_data_o), .port_wr_o(port_wr_o),
        .halt_o(halt_o)
    );

    initial begin
        pin_clk = 1'b0;
        forever #20 pin_clk = ~pin_clk;
    end

    assign mem_data_i = mem[mem_addr_o[7:0]];   // Combinational read

    // Memory writes and port capture
    always @(posedge pin_clk) begin
        if (rst_n_i) begin
            if (port_wr_o)
                outs.push_back({port_addr_o, port_data_o});
            else if (port_addr_o != 8'h00)
                in_addr = port_addr_o;          // Only IN shows a port without a write
            if (mem_wr_o) begin
                mem[mem_addr_o[7:0]] <= mem_data_o;
                wr_cnt  = wr_cnt + 1;
                wr_addr = mem_addr_o;
                wr_data = mem_data_o;
            end
        end
    end

    always @(posedge pin_clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: program did not reach HALT within %0d cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [7:0] lcg_byte();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    // Expected accumulator after an ALU op
    function automatic logic [7:0] alu_ref(input int op, input logic [7:0] a,
                                           input logic [7:0] b, input logic c);
        case (op)
            0: return a + b;
            1: return a + b + c;
            2: return a - b;
            3: return a - b - c;
            4: return a & b;
            5: return a ^ b;
            6: return a | b;
            default: return a;      // CP keeps A
        endcase
    endfunction

    task automatic begin_entry(input string nm, input logic [7:0] inv);
        t_name[ne] = nm;
        t_in[ne]   = inv;
        t_inp[ne]  = 8'h00;
        t_len[ne]  = 0;
        t_nexp[ne] = 0;
        t_wa[ne]   = -1;
    endtask

    task automatic emit(input logic [7:0] b);
        t_prog[ne][t_len[ne]] = b;
        t_len[ne] = t_len[ne] + 1;
    endtask

    task automatic expect_out(input logic [7:0] port, input logic [7:0] data);
        t_exp[ne][t_nexp[ne]] = {port, data};
        t_nexp[ne] = t_nexp[ne] + 1;
    endtask

    task automatic end_entry();
        emit(`KR580_OP_HALT);
        t_hpos[ne] = t_len[ne] - 1;
        ne = ne + 1;
    endtask

    task automatic build_table();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] d;
        logic [1:0] sel;
        logic       sense;
        logic       flag;
        for (int g = 0; g < 2; g++) begin
            begin_entry(g == 0 ? "ld_bcd" : "ld_ehl", 8'h00);
            for (int r = 3 * g; r < 3 * g + 3; r++) begin
                a = lcg_byte();
                emit({2'b00, 3'(r), 3'b110});       // LD r,i8
                emit(a);
                emit({2'b01, `KR580_REG_A, 3'(r)}); // LD A,r
                emit(`KR580_OP_OUT);
                emit(8'h10 + 8'(r));
                expect_out(8'h10 + 8'(r), a);
            end
            end_entry();
        end
        for (int op = 0; op < 8; op++) begin
            for (int c = 0; c < 2; c++) begin
                a = lcg_byte();
                b = lcg_byte();
                begin_entry($sformatf("alu_op%0d_c%0d", op, c), 8'h00);
                emit(8'h3E);
                emit(8'hFF);
                emit(8'hC6);                        // ADD sets carry only when c is 1
                emit(8'(c));
                emit(8'h3E);
                emit(a);
                if (c == 0) begin
                    emit(8'h06);                    // LD B,i8
                    emit(b);
                    emit({2'b10, 3'(op), `KR580_REG_B});
                end else begin
                    emit({2'b11, 3'(op), 3'b110});  // Immediate form
                    emit(b);
                end
                emit(`KR580_OP_OUT);
                emit(8'h20);
                expect_out(8'h20, alu_ref(op, a, b, 1'(c)));
                end_entry();
            end
        end
        for (int j = 0; j < 6; j++) begin
            a     = lcg_byte();
            b     = (j == 5) ? a : lcg_byte();
            sel   = (j < 4) ? 2'(j) : 2'd0;
            sense = (j == 5) ? 1'b1 : lcg_byte() ^ 8'h00 ? seed[7] : 1'b0;
            d     = a - b;
            case (sel)
                2'd0: flag = (d == 8'h00);
                2'd1: flag = (a < b);               // Borrow
                2'd2: flag = ~^d;
                default: flag = d[7];
            endcase
            if (j == 4)
                flag = sense;                       // Unconditional JP
            begin_entry($sformatf("jp_case%0d", j), 8'h00);
            emit(8'h3E);
            emit(a);
            emit(8'hFE);                            // CP i8
            emit(b);
            emit((j == 4) ? `KR580_OP_JP : {2'b11, sel, sense, 3'b010});
            emit(8'h0A);
            emit(8'h00);
            emit(`KR580_OP_OUT);                    // Fall-through marker
            emit(8'h01);
            emit(`KR580_OP_HALT);
            emit(`KR580_OP_OUT);                    // Target at 0x0A
            emit(8'h02);
            expect_out((flag == sense) ? 8'h02 : 8'h01, a);
            end_entry();
            if (flag != sense)
                t_hpos[ne - 1] = 9;
        end
        a = lcg_byte();
        begin_entry("mem_hl", 8'h00);
        emit(8'h26);
        emit(8'h00);
        emit(8'h2E);
        emit(8'h80);
        emit(8'h3E);
        emit(a);
        emit(8'h77);                                // LD (HL),A
        emit(8'h3E);
        emit(8'h00);
        emit(8'h46);                                // LD B,(HL)
        emit(8'h78);
        emit(`KR580_OP_OUT);
        emit(8'h05);
        expect_out(8'h05, a);
        t_wa[ne] = 16'h0080;
        t_wd[ne] = a;
        end_entry();
        a = lcg_byte();
        b = lcg_byte();
        begin_entry("in_add", a);
        t_inp[ne] = 8'h33;
        emit(`KR580_OP_IN);
        emit(8'h33);
        emit(8'hC6);
        emit(b);
        emit(`KR580_OP_OUT);
        emit(8'h06);
        expect_out(8'h06, a + b);
        end_entry();
    endtask

    task automatic wait_cycle();
        @(posedge pin_clk);
        #2;
    endtask

    task automatic run_entry(input int e);
        wait_cycle();
        rst_n_i     = 1'b0;
        port_data_i = t_in[e];
        for (int i = 0; i < 256; i++)
            mem[i] = 8'h00;                         // Unused opcodes run as NOP
        for (int i = 0; i < t_len[e]; i++)
            mem[i] = t_prog[e][i];
        outs.delete();
        wr_cnt  = 0;
        in_addr = 8'h00;
        wait_cycle();
        assert (!mem_wr_o && !port_wr_o && !halt_o && mem_addr_o == `KR580_RESET_PC)
            else begin
                err_cnt++;
                $display("%s: outputs not idle during reset", t_name[e]);
            end
        wait_cycle();
        rst_n_i = 1'b1;
        while (!halt_o)
            wait_cycle();
        wait_cycle();
        wait_cycle();
        assert (mem_addr_o == 16'(t_hpos[e]))
            else begin
                err_cnt++;
                $display("ERR %s %h %h", t_name[e], 16'(t_hpos[e]), mem_addr_o);
            end
        assert (outs.size() == t_nexp[e])
            else begin
                err_cnt++;
                $display("%s: expected %0d port writes but saw %0d",
                         t_name[e], t_nexp[e], outs.size());
            end
        for (int i = 0; i < t_nexp[e] && i < outs.size(); i++) begin
            assert (outs[i] == t_exp[e][i])
                else begin
                    err_cnt++;
                    $display("ERR %s %h %h", t_name[e], t_exp[e][i], outs[i]);
                end
        end
        if (t_inp[e] != 8'h00) begin
            assert (in_addr == t_inp[e])
                else begin
                    err_cnt++;
                    $display("ERR %s %h %h", t_name[e], t_inp[e], in_addr);
                end
        end
        if (t_wa[e] < 0) begin
            assert (wr_cnt == 0)
                else begin
                    err_cnt++;
                    $display("%s: unexpected memory write", t_name[e]);
                end
        end else begin
            assert (wr_cnt == 1 && wr_addr == 16'(t_wa[e]) && wr_data == t_wd[e])
                else begin
                    err_cnt++;
                    $display("ERR %s %h %h", t_name[e], {16'(t_wa[e]), t_wd[e]},
                             {wr_addr, wr_data});
                end
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        port_data_i = 8'h00;
        err_cnt     = 0;
        cycles      = 0;
        wr_cnt      = 0;
        ne          = 0;
        seed        = 32'd62787;
        for (int i = 0; i < 256; i++)
            mem[i] = 8'h00;
        build_table();
        for (int e = 0; e < ne; e++)
            run_entry(e);
        $display("errors: %0d failed checks over %0d programs", err_cnt, ne);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* kr580_lite.f */
+incdir+verilog
verilog/kr580_pkg.sv
verilog/kr580_alu.sv
verilog/kr580_regfile.sv
verilog/kr580_control.sv
verilog/kr580_core.sv
verification/kr580_tb.sv
